//--- Makefile
# Verilator build for the local-memory test subsystem

TOP = lm_test_tb

.PHONY: sim lint clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir

//--- all.f
+incdir+common
common/lmt_bus_pkg.sv
common/lmt_engine_pkg.sv
mem_engine/mem_check.sv
mem_engine/mem_engine.sv
hdl/csr_mgr.sv
hdl/lm_test_top.sv
testbench/lm_test_checker.sv
testbench/lm_test_monitor.sv
testbench/lm_test_tb.sv

//--- common/lm_test_config.svh
// ======================================================================
// Local-memory test configuration
// Engine count, bank geometry and the test identifier
// ======================================================================

`ifndef LM_TEST_CONFIG_SVH
`define LM_TEST_CONFIG_SVH

// One engine per memory bank
`define LMT_NUM_ENGINES 2

// Bank word-address width
`define LMT_ADDR_W 10

// Data word width on host and memory buses
`define LMT_DATA_W 32

// Value of global register 0
`define LMT_TEST_ID 32'h4c4d_0001

`endif

//--- common/lmt_bus_pkg.sv
// ======================================================================
// Wishbone classic bus types
// Request and response bundles for the host port and memory ports
// ======================================================================

`default_nettype none

`include "lm_test_config.svh"

package lmt_bus_pkg;

    // Master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [15:0]            adr;
        logic [`LMT_DATA_W-1:0] dat;
    } wb_req_t;

    // Slave to master, dat valid with ack
    typedef struct packed {
        logic                   ack;
        logic [`LMT_DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- common/lmt_engine_pkg.sv
// ======================================================================
// Test engine types
// Command and status bundles and the register map offsets
// ======================================================================

`default_nettype none

`include "lm_test_config.svh"

package lmt_engine_pkg;

    // Register manager to engine
    typedef struct packed {
        logic [`LMT_ADDR_W-1:0] base;
        logic [`LMT_ADDR_W-1:0] len;
        logic [`LMT_DATA_W-1:0] seed;
        logic                   start;
    } eng_cmd_t;

    // Engine to register manager
    typedef struct packed {
        logic                   busy;
        logic                   done;
        logic [15:0]            err_count;
        logic [`LMT_ADDR_W-1:0] first_err_addr;
        logic                   first_err_valid;
    } eng_status_t;

    // Per-engine offsets within a 16-word window
    localparam logic [3:0] REG_BASE      = 4'd0;
    localparam logic [3:0] REG_LEN       = 4'd1;
    localparam logic [3:0] REG_SEED      = 4'd2;
    localparam logic [3:0] REG_CTRL      = 4'd3;
    localparam logic [3:0] REG_STATUS    = 4'd4;
    localparam logic [3:0] REG_ERR_CNT   = 4'd5;
    localparam logic [3:0] REG_FIRST_ERR = 4'd6;

    // Global window offsets
    localparam logic [3:0] GLB_TEST_ID = 4'd0;
    localparam logic [3:0] GLB_NUM_ENG = 4'd1;

endpackage

`default_nettype wire

//--- hdl/csr_mgr.sv
// ======================================================================
// Register manager
// Host register decode, engine command registers and status readback
// ======================================================================

`default_nettype none

`include "lm_test_config.svh"

module csr_mgr
    import lmt_bus_pkg::*, lmt_engine_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  wb_req_t     host_req,
    output wb_rsp_t     host_rsp,
    output eng_cmd_t    eng_cmd [`LMT_NUM_ENGINES],
    input  eng_status_t eng_status [`LMT_NUM_ENGINES]
);

    localparam int NE = `LMT_NUM_ENGINES;
    localparam int AW = `LMT_ADDR_W;
    localparam int DW = `LMT_DATA_W;

    logic          ack_q;
    logic          req_hit;
    logic          wr_en;
    logic [11:0]   win;
    logic [3:0]    off;
    logic [DW-1:0] rd_data;
    logic [DW-1:0] rd_q;
    logic [NE-1:0] ctrl_start;
    eng_cmd_t      cmd_q [NE];

    // Window 0 is global, window e+1 belongs to engine e
    assign win = host_req.adr[15:4];
    assign off = host_req.adr[3:0];

    // No new hit during the ack cycle, the master still holds stb there
    assign req_hit = host_req.cyc && host_req.stb && !ack_q;
    assign wr_en   = req_hit && host_req.we;

    // ==================================================================
    // Read mux
    // ==================================================================
    always_comb
    begin
        rd_data = '0;
        if (win == '0)
        begin
            case (off)
                GLB_TEST_ID: rd_data = `LMT_TEST_ID;
                GLB_NUM_ENG: rd_data = DW'(NE);
                default:     rd_data = '0;
            endcase
        end
        for (int e = 0; e < NE; e++)
        begin
            if (win == 12'(e + 1))
            begin
                case (off)
                    REG_BASE:      rd_data = DW'(cmd_q[e].base);
                    REG_LEN:       rd_data = DW'(cmd_q[e].len);
                    REG_SEED:      rd_data = cmd_q[e].seed;
                    REG_CTRL:      rd_data = DW'(ctrl_start[e]);
                    // Bit 0 busy, bit 1 done, bit 2 first error valid
                    REG_STATUS:    rd_data = DW'({eng_status[e].first_err_valid,
                                                  eng_status[e].done,
                                                  eng_status[e].busy});
                    REG_ERR_CNT:   rd_data = DW'(eng_status[e].err_count);
                    REG_FIRST_ERR: rd_data = DW'(eng_status[e].first_err_addr);
                    default:       rd_data = '0;
                endcase
            end
        end
    end

    // ==================================================================
    // Ack, command registers and start pulse
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ack_q      <= 1'b0;
            ctrl_start <= '0;
            for (int e = 0; e < NE; e++)
            begin
                cmd_q[e] <= '0;
            end
        end
        else
        begin
            ack_q <= req_hit;
            for (int e = 0; e < NE; e++)
            begin
                // Start bit is set in the ack cycle and fires one cycle later
                cmd_q[e].start <= ctrl_start[e];
                ctrl_start[e]  <= 1'b0;
                if (wr_en && win == 12'(e + 1))
                begin
                    case (off)
                        REG_BASE: cmd_q[e].base <= host_req.dat[AW-1:0];
                        REG_LEN:  cmd_q[e].len  <= host_req.dat[AW-1:0];
                        REG_SEED: cmd_q[e].seed <= host_req.dat;
                        REG_CTRL: ctrl_start[e] <= host_req.dat[0];
                        default:  ;
                    endcase
                end
            end
        end
    end

    // Read data captured with the request, returned with ack
    always_ff @(posedge clk)
    begin
        if (req_hit)
        begin
            rd_q <= rd_data;
        end
    end

    assign host_rsp.ack = ack_q;
    assign host_rsp.dat = rd_q;
    assign eng_cmd      = cmd_q;

endmodule

`default_nettype wire

//--- hdl/lm_test_top.sv
// ======================================================================
// Local-memory test subsystem top
// Register manager plus one test engine per memory bank
// ======================================================================

`default_nettype none

`include "lm_test_config.svh"

module lm_test_top
    import lmt_bus_pkg::*, lmt_engine_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t host_req,
    output wb_rsp_t host_rsp,
    output wb_req_t mem_req [`LMT_NUM_ENGINES],
    input  wb_rsp_t mem_rsp [`LMT_NUM_ENGINES]
);

    eng_cmd_t    eng_cmd    [`LMT_NUM_ENGINES];
    eng_status_t eng_status [`LMT_NUM_ENGINES];

    // ==================================================================
    // Host register window
    // ==================================================================
    csr_mgr u_csr_mgr (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .eng_cmd    (eng_cmd),
        .eng_status (eng_status)
    );

    // ==================================================================
    // Engines, one per bank
    // ==================================================================
    generate
        for (genvar e = 0; e < `LMT_NUM_ENGINES; e++)
        begin : g_eng
            mem_engine u_mem_engine (
                .clk     (clk),
                .rst_n   (rst_n),
                .cmd     (eng_cmd[e]),
                .status  (eng_status[e]),
                .mem_req (mem_req[e]),
                .mem_rsp (mem_rsp[e])
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- mem_engine/mem_check.sv
// ======================================================================
// Read-back comparator
// Counts words that differ from address XOR seed, keeps first bad address
// ======================================================================

`default_nettype none

`include "lm_test_config.svh"

module mem_check (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  logic                   beat_valid,
    input  logic [`LMT_ADDR_W-1:0] beat_addr,
    input  logic [`LMT_DATA_W-1:0] beat_data,
    input  logic [`LMT_DATA_W-1:0] seed,
    output logic [15:0]            err_count,
    output logic [`LMT_ADDR_W-1:0] first_err_addr,
    output logic                   first_err_valid
);

    localparam int DW = `LMT_DATA_W;

    logic [DW-1:0] expected;
    logic          mismatch;

    assign expected = DW'(beat_addr) ^ seed;
    assign mismatch = beat_valid && (beat_data != expected);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            err_count       <= '0;
            first_err_addr  <= '0;
            first_err_valid <= 1'b0;
        end
        else if (clear)
        begin
            err_count       <= '0;
            first_err_addr  <= '0;
            first_err_valid <= 1'b0;
        end
        else if (mismatch)
        begin
            // Saturate instead of wrapping
            if (err_count != '1)
            begin
                err_count <= err_count + 1'b1;
            end
            if (!first_err_valid)
            begin
                first_err_addr  <= beat_addr;
                first_err_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- mem_engine/mem_engine.sv
// ======================================================================
// Memory test engine
// Writes a region with address XOR seed, then reads it back for checking
// ======================================================================

`default_nettype none

`include "lm_test_config.svh"

module mem_engine
    import lmt_bus_pkg::*, lmt_engine_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  eng_cmd_t    cmd,
    output eng_status_t status,
    output wb_req_t     mem_req,
    input  wb_rsp_t     mem_rsp
);

    localparam int AW = `LMT_ADDR_W;
    localparam int DW = `LMT_DATA_W;

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ, ST_DONE} state_t;

    state_t        state;
    logic          req_stb;
    logic [AW-1:0] idx;
    logic [AW-1:0] base_q;
    logic [AW-1:0] len_q;
    logic [DW-1:0] seed_q;
    logic [AW-1:0] cur_addr;
    logic          start_ok;
    logic          last_word;
    logic          beat_valid;
    logic [15:0]   err_count;
    logic [AW-1:0] first_err_addr;
    logic          first_err_valid;

    // Start is ignored while a run is in progress
    assign start_ok   = cmd.start && (state == ST_IDLE || state == ST_DONE);
    assign cur_addr   = base_q + idx;
    assign last_word  = (idx == len_q - 1'b1);
    assign beat_valid = (state == ST_READ) && req_stb && mem_rsp.ack;

    // ==================================================================
    // Sequencer
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= ST_IDLE;
            req_stb <= 1'b0;
            idx     <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE, ST_DONE:
                begin
                    if (start_ok)
                    begin
                        idx     <= '0;
                        req_stb <= 1'b0;
                        // Zero length finishes at once with no traffic
                        state   <= (cmd.len == '0) ? ST_DONE : ST_WRITE;
                    end
                end
                ST_WRITE, ST_READ:
                begin
                    if (!req_stb)
                    begin
                        req_stb <= 1'b1;
                    end
                    else if (mem_rsp.ack)
                    begin
                        // Drop stb for a cycle between words
                        req_stb <= 1'b0;
                        idx     <= idx + 1'b1;
                        if (last_word)
                        begin
                            idx   <= '0;
                            state <= (state == ST_WRITE) ? ST_READ : ST_DONE;
                        end
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Run parameters held for the whole run
    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            base_q <= cmd.base;
            len_q  <= cmd.len;
            seed_q <= cmd.seed;
        end
    end

    // Request fields only change on ack, so they stay stable while waiting
    always_comb
    begin
        mem_req.cyc = req_stb;
        mem_req.stb = req_stb;
        mem_req.we  = (state == ST_WRITE);
        mem_req.adr = 16'(cur_addr);
        mem_req.dat = (state == ST_WRITE) ? (DW'(cur_addr) ^ seed_q) : '0;
    end

    mem_check u_mem_check (
        .clk             (clk),
        .rst_n           (rst_n),
        .clear           (start_ok),
        .beat_valid      (beat_valid),
        .beat_addr       (cur_addr),
        .beat_data       (mem_rsp.dat),
        .seed            (seed_q),
        .err_count       (err_count),
        .first_err_addr  (first_err_addr),
        .first_err_valid (first_err_valid)
    );

    assign status.busy            = (state == ST_WRITE) || (state == ST_READ);
    assign status.done            = (state == ST_DONE);
    assign status.err_count       = err_count;
    assign status.first_err_addr  = first_err_addr;
    assign status.first_err_valid = first_err_valid;

endmodule

`default_nettype wire

//--- testbench/lm_test_checker.sv
// ======================================================================
// Memory bus protocol assertions, bound into every test engine
// ======================================================================

`default_nettype none

`include "lm_test_config.svh"

module lm_test_checker
    import lmt_bus_pkg::*, lmt_engine_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  wb_req_t     mem_req,
    input  wb_rsp_t     mem_rsp,
    input  eng_status_t status
);

    timeunit 1ns;
    timeprecision 100ps;

    // Assertion failures so far
    int fail_count = 0;

    // Master keeps stb up until the bank acks
    stb_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.stb && !mem_rsp.ack |=> mem_req.stb)
    else
    begin
        $error("Memory stb dropped before ack");
        fail_count++;
    end

    // Address, data and direction frozen while waiting
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.stb && !mem_rsp.ack |=> $stable(mem_req))
    else
    begin
        $error("Memory request changed while waiting for ack");
        fail_count++;
    end

    no_idle_req: assert property (@(posedge clk) disable iff (!rst_n)
        !status.busy |-> !mem_req.cyc)
    else
    begin
        $error("Memory cycle started while the engine is not busy");
        fail_count++;
    end

    // A run ends with busy falling and done rising in the same cycle
    done_on_finish: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(status.busy) |-> $rose(status.done))
    else
    begin
        $error("Engine left the busy state without raising done");
        fail_count++;
    end

endmodule

bind mem_engine lm_test_checker u_lm_test_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .status  (status)
);

`default_nettype wire

//--- testbench/lm_test_monitor.sv
// ======================================================================
// Result monitor
// Compares host reads and bank peeks with expected values, keeps totals
// ======================================================================

`default_nettype none

module lm_test_monitor
    import lmt_bus_pkg::*;
(
    input  logic        clk,
    input  wb_req_t     host_req,
    input  wb_rsp_t     host_rsp,
    input  logic        exp_valid,
    input  logic [31:0] exp_data,
    input  logic        peek_valid,
    input  logic [31:0] peek_got,
    input  logic [31:0] peek_exp,
    input  logic        test_end,
    input  logic [7:0]  test_num,
    input  logic        run_end,
    output int          errors,
    output int          tests
);

    timeunit 1ns;
    timeprecision 100ps;

    int checks    = 0;
    int err_total = 0;
    int test_errs = 0;
    int test_cnt  = 0;

    assign errors = err_total;
    assign tests  = test_cnt;

    // Falling edge, so every DUT and driver signal has settled
    always @(negedge clk)
    begin
        if (host_rsp.ack && !host_req.we && exp_valid)
        begin
            checks++;
            if (host_rsp.dat !== exp_data)
            begin
                $display("[FAIL] %0t: read of 0x%04h returned 0x%08h, expected 0x%08h",
                         $time, host_req.adr, host_rsp.dat, exp_data);
                test_errs++;
                err_total++;
            end
        end
        if (peek_valid)
        begin
            checks++;
            if (peek_got !== peek_exp)
            begin
                $display("[FAIL] %0t: bank word is 0x%08h, expected 0x%08h",
                         $time, peek_got, peek_exp);
                test_errs++;
                err_total++;
            end
        end
        if (test_end)
        begin
            test_cnt++;
            if (test_errs == 0)
                $display("test %0d passed", test_num);
            else
                $display("test %0d failed with %0d mismatches", test_num, test_errs);
            test_errs = 0;
        end
        if (run_end)
        begin
            $display("%0d tests, %0d checks, %0d mismatches", test_cnt, checks, err_total);
        end
    end

endmodule

`default_nettype wire

//--- testbench/lm_test_tb.sv
// ======================================================================
// Testbench for the local-memory test subsystem
// Vector-driven host bus, memory bank models with stuck bits, timeout
// ======================================================================

`default_nettype none

`include "lm_test_config.svh"

module lm_test_tb
    import lmt_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NE        = `LMT_NUM_ENGINES;
    localparam int AW        = `LMT_ADDR_W;
    localparam int DEPTH     = 1 << AW;
    localparam int VEC_WORDS = 3 * 128;

    logic        clk = 1'b0;
    logic        rst_n;
    wb_req_t     host_req;
    wb_rsp_t     host_rsp;
    wb_req_t     mem_req [NE];
    wb_rsp_t     mem_rsp [NE];

    logic [31:0] vec [VEC_WORDS];
    logic [31:0] bank_mem [NE][DEPTH];
    logic        bank_fault [NE][DEPTH];
    logic        pend [NE];
    int          wait_cnt [NE];
    int          run_len [NE];
    integer      seed = 32'hf9f6_7570;
    int          cycles = 0;
    int          limit = 0;

    logic        exp_valid;
    logic [31:0] exp_data;
    logic        peek_valid;
    logic [31:0] peek_got;
    logic [31:0] peek_exp;
    logic        test_end;
    logic [7:0]  test_num;
    logic        run_end;
    int          mon_errors;
    int          mon_tests;
    int          assert_fails;

    always #2 clk = ~clk;

    lm_test_top u_lm_test_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    lm_test_monitor u_lm_test_monitor (
        .clk        (clk),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .exp_valid  (exp_valid),
        .exp_data   (exp_data),
        .peek_valid (peek_valid),
        .peek_got   (peek_got),
        .peek_exp   (peek_exp),
        .test_end   (test_end),
        .test_num   (test_num),
        .run_end    (run_end),
        .errors     (mon_errors),
        .tests      (mon_tests)
    );

    // ==================================================================
    // Bank models, random ack delay of 0 to 3 cycles per request
    // ==================================================================
    always @(posedge clk)
    begin
        #0.5;
        for (int b = 0; b < NE; b++)
        begin
            if (mem_rsp[b].ack)
            begin
                mem_rsp[b].ack = 1'b0;
                pend[b]        = 1'b0;
            end
            else if (mem_req[b].cyc && mem_req[b].stb)
            begin
                if (!pend[b])
                begin
                    pend[b]     = 1'b1;
                    wait_cnt[b] = $unsigned($random(seed)) % 4;
                end
                if (wait_cnt[b] == 0)
                begin
                    if (mem_req[b].we)
                        bank_mem[b][mem_req[b].adr[AW-1:0]] = mem_req[b].dat;
                    else
                        // Stuck bit 0 on a faulted word
                        mem_rsp[b].dat = bank_mem[b][mem_req[b].adr[AW-1:0]]
                                         ^ {31'b0, bank_fault[b][mem_req[b].adr[AW-1:0]]};
                    mem_rsp[b].ack = 1'b1;
                end
                else
                begin
                    wait_cnt[b]--;
                end
            end
        end
    end

    // Cycle limit, set from the run lengths in the vectors
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // One Wishbone classic cycle on the host port
    task automatic host_xfer(input logic we, input logic [15:0] adr,
                             input logic [31:0] dat, output logic [31:0] rdata);
        @(posedge clk);
        #0.5;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = dat;
        do
        begin
            @(posedge clk);
            #0.5;
        end
        while (!host_rsp.ack);
        rdata = host_rsp.dat;
        @(posedge clk);
        #0.5;
        host_req = '0;
    endtask

    initial
    begin
        logic [31:0] op;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [31:0] rd;
        int          i;
        int          e;

        for (i = 0; i < VEC_WORDS; i++)
            vec[i] = '0;
        $readmemh("testbench/lm_test_vectors.txt", vec);

        // Per run 2 passes of 4 cycles per word, plus 50 per test
        for (e = 0; e < NE; e++)
            run_len[e] = 0;
        for (i = 0; i < VEC_WORDS; i += 3)
        begin
            if (vec[i] == 32'h1 && vec[i+1][15:4] != '0 && vec[i+1][15:4] <= NE)
            begin
                e = int'(vec[i+1][15:4]) - 1;
                if (vec[i+1][3:0] == 4'd1)
                    run_len[e] = int'(vec[i+2]);
                if (vec[i+1][3:0] == 4'd3)
                    limit += 8 * run_len[e];
            end
            if (vec[i] == 32'hf)
                limit += 50;
        end

        // Fill pattern marks words that no engine wrote
        for (int b = 0; b < NE; b++)
        begin
            pend[b]     = 1'b0;
            wait_cnt[b] = 0;
            mem_rsp[b]  = '0;
            for (int a = 0; a < DEPTH; a++)
            begin
                bank_mem[b][a]   = 32'hb000_0000 + (b << 24) + a;
                bank_fault[b][a] = 1'b0;
            end
        end
        rst_n      = 1'b0;
        host_req   = '0;
        exp_valid  = 1'b0;
        exp_data   = '0;
        peek_valid = 1'b0;
        peek_got   = '0;
        peek_exp   = '0;
        test_end   = 1'b0;
        test_num   = '0;
        run_end    = 1'b0;
        repeat (5) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        // ==============================================================
        // Vector loop
        // ==============================================================
        i = 0;
        while (i < VEC_WORDS && vec[i] != 32'h0)
        begin
            op  = vec[i];
            adr = vec[i+1];
            dat = vec[i+2];
            case (op)
                32'h1: host_xfer(1'b1, adr[15:0], dat, rd);
                32'h2:
                begin
                    exp_data  = dat;
                    exp_valid = 1'b1;
                    host_xfer(1'b0, adr[15:0], '0, rd);
                    exp_valid = 1'b0;
                end
                32'h3:
                begin
                    rd = '0;
                    while ((rd & dat) == '0)
                        host_xfer(1'b0, adr[15:0], '0, rd);
                end
                // Bank number in address bits 15:12
                32'h4: bank_fault[int'(adr[15:12])][adr[AW-1:0]] = 1'b1;
                32'h5:
                begin
                    @(posedge clk);
                    #0.5;
                    peek_got   = bank_mem[int'(adr[15:12])][adr[AW-1:0]];
                    peek_exp   = dat;
                    peek_valid = 1'b1;
                    @(posedge clk);
                    #0.5;
                    peek_valid = 1'b0;
                end
                32'hf:
                begin
                    @(posedge clk);
                    #0.5;
                    test_num = dat[7:0];
                    test_end = 1'b1;
                    @(posedge clk);
                    #0.5;
                    test_end = 1'b0;
                end
                default: $display("Skipping unknown vector operation %0h", op);
            endcase
            i += 3;
        end

        @(posedge clk);
        #0.5;
        run_end = 1'b1;
        @(posedge clk);
        #0.5;
        run_end = 1'b0;

        assert_fails = u_lm_test_top.g_eng[0].u_mem_engine.u_lm_test_checker.fail_count
                     + u_lm_test_top.g_eng[1].u_mem_engine.u_lm_test_checker.fail_count;
        if (assert_fails != 0)
            $display("Memory bus assertions failed %0d times", assert_fails);
        if (mon_tests == 0)
            $display("No tests were run from the vector file");
        if (mon_errors == 0 && assert_fails == 0 && mon_tests != 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/lm_test_vectors.txt
// Columns: op address data, all hex. Op 1 write, 2 read and expect, 3 poll until data bits set
// 4 fault {bank, word}, 5 peek {bank, word} and expect, f end of test, 0 end of run
// Test 1: global registers, unmapped reads
2 0000 4c4d0001
2 0001 00000002
2 0007 00000000
2 0035 00000000
f 0000 00000001
// Test 2: command readback, start self-clears
1 0010 00000020
1 0011 00000010
1 0012 a5a50000
2 0010 00000020
2 0011 00000010
2 0012 a5a50000
1 0013 00000001
2 0013 00000000
f 0000 00000002
// Test 3: clean run on engine 0
3 0014 00000002
2 0014 00000002
2 0015 00000000
2 0016 00000000
5 0020 a5a50020
5 002f a5a5002f
5 0030 b0000030
f 0000 00000003
// Test 4: three faults in range, one outside
4 0045 00000000
4 0042 00000000
4 004a 00000000
4 0050 00000000
1 0010 00000040
1 0012 12345678
1 0013 00000001
3 0014 00000002
2 0014 00000006
2 0015 00000003
2 0016 00000042
f 0000 00000004
// Test 5: both engines together, one fault in bank 1
4 1085 00000000
1 0010 00000100
1 0011 00000020
1 0012 0f0f0f0f
1 0020 00000080
1 0021 00000018
1 0022 c3c3c3c3
1 0013 00000001
1 0023 00000001
3 0014 00000002
3 0024 00000002
2 0014 00000002
2 0015 00000000
2 0016 00000000
2 0024 00000006
2 0025 00000001
2 0026 00000085
5 0100 0f0f0e0f
5 011f 0f0f0e10
5 1080 c3c3c343
5 1097 c3c3c354
f 0000 00000005
// Test 6: zero length on engine 1, second start while engine 0 is busy
1 0021 00000000
1 0023 00000001
3 0024 00000002
2 0024 00000002
2 0025 00000000
4 0203 00000000
1 0010 00000200
1 0011 00000010
1 0012 55aa55aa
1 0013 00000001
1 0012 00000000
1 0013 00000001
3 0014 00000002
2 0014 00000006
2 0015 00000001
2 0016 00000203
5 0200 55aa57aa
f 0000 00000006
0 0000 00000000
